// File: common/game_consts.svh
`ifndef GAME_CONSTS_SVH
`define GAME_CONSTS_SVH

// Palette RAM window on the main CPU bus, 512 bytes
`define GAME_PAL_BASE    16'h4000
`define GAME_PAL_LAST    16'h41FF

// Palette depth in 16-bit words
`define GAME_PAL_WORDS   256

// Layer priority register, data bit 0
`define GAME_PRIO_ADDR   16'h5C80

// Sound latch, one address per board variant
`define GAME_LATCH_ADDR0 16'h5C00
`define GAME_LATCH_ADDR1 16'h5F88

// Download header carrying the variant bit
`define GAME_HDR_ADDR    25'd0

`endif

// File: common/game_bus_pkg.sv
package game_bus_pkg;

    // Main CPU write strobe with address and data
    typedef struct packed {
        logic        we;
        logic [15:0] addr;
        logic [ 7:0] data;
    } cpu_wr_t;

    // ROM download port
    typedef struct packed {
        logic        we;
        logic        header;
        logic [24:0] addr;
        logic [ 7:0] data;
    } prog_wr_t;

    // Per-block status byte for the debug view
    typedef logic [7:0] status_t;

    // Debug view select
    //   0 main, 1 video, 2 sound, 3 cfg and prio
    typedef logic [1:0] debug_sel_t;

endpackage

// File: common/game_video_pkg.sv
package game_video_pkg;

    // One layer pixel, transparent when col is zero
    typedef struct packed {
        logic [2:0] pal;
        logic [3:0] col;
    } layer_pxl_t;

    // Mixer output
    // idx is {obj, pal, col}
    typedef struct packed {
        logic       valid;
        logic       blank;
        logic [7:0] idx;
    } mix_pxl_t;

    // Colour fields of a palette word, red in the low bits
    typedef struct packed {
        logic       unused;
        logic [4:0] blue;
        logic [4:0] green;
        logic [4:0] red;
    } rgb555_t;

    // Palette word as the CPU writes it (byte lanes, lane 0 is the even byte)
    // or as the pixel path reads it
    typedef union packed {
        logic [1:0][7:0] raw;
        rgb555_t         rgb;
    } pal_word_u;

    // Colour to the video output
    typedef struct packed {
        logic [4:0] red;
        logic [4:0] green;
        logic [4:0] blue;
    } rgb_t;

endpackage

// File: source/main_decode.sv
`include "game_consts.svh"

module main_decode (
    input  logic                  clk,
    input  logic                  reset,
    input  game_bus_pkg::cpu_wr_t cpu,
    input  logic                  cfg,
    output logic                  pal_we,
    output logic [8:0]            pal_addr,
    output logic [7:0]            pal_data,
    output logic                  prio,
    output logic                  latch_we,
    output logic [7:0]            latch_data,
    output game_bus_pkg::status_t st_main
);

    logic        pal_hit;
    logic        prio_hit;
    logic        latch_hit;
    logic [15:0] latch_addr;

    // The two board variants place the sound latch differently
    assign latch_addr = cfg ? `GAME_LATCH_ADDR1 : `GAME_LATCH_ADDR0;

    assign pal_hit   = cpu.addr >= `GAME_PAL_BASE && cpu.addr <= `GAME_PAL_LAST;
    assign prio_hit  = cpu.addr == `GAME_PRIO_ADDR;
    assign latch_hit = cpu.addr == latch_addr;

    // Palette window is 512-byte aligned, so the low bits index it directly
    assign pal_we   = cpu.we && pal_hit;
    assign pal_addr = cpu.addr[8:0];
    assign pal_data = cpu.data;

    assign latch_we   = cpu.we && latch_hit;
    assign latch_data = cpu.data;

    always_ff @(posedge clk) begin
        if (reset) begin
            prio <= 1'b0;
        end else if (cpu.we && prio_hit) begin
            prio <= cpu.data[0];
        end
    end

    // Palette byte writes, wraps at 256
    always_ff @(posedge clk) begin
        if (reset) begin
            st_main <= '0;
        end else if (pal_we) begin
            st_main <= st_main + 8'd1;
        end
    end

    // Latch address must never fall inside the palette window for either variant
    assert property (@(posedge clk) disable iff (reset) !(pal_we && latch_we))
        else $error("palette and latch write decoded together");

endmodule

// File: source/sound_latch.sv
module sound_latch (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  latch_we,
    input  logic [7:0]            latch_data,
    input  logic                  snd_ack,
    output logic [7:0]            snd_latch,
    output logic                  snd_irq,
    output game_bus_pkg::status_t st_snd
);

    // Command byte
    always_ff @(posedge clk) begin
        if (latch_we) begin
            snd_latch <= latch_data;
        end
    end

    // Pending interrupt, a new command wins over an ack in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            snd_irq <= 1'b0;
        end else if (latch_we) begin
            snd_irq <= 1'b1;
        end else if (snd_ack) begin
            snd_irq <= 1'b0;
        end
    end

    // Commands sent to the sound side
    always_ff @(posedge clk) begin
        if (reset) begin
            st_snd <= '0;
        end else if (latch_we) begin
            st_snd <= st_snd + 8'd1;
        end
    end

    // Sound CPU must not see a stale interrupt coming out of reset
    assert property (@(posedge clk) reset |=> !snd_irq)
        else $error("snd_irq high after reset");

endmodule

// File: source/game_status.sv
`include "game_consts.svh"

module game_status (
    input  logic                     clk,
    input  logic                     reset,
    input  game_bus_pkg::prog_wr_t   prog,
    input  game_bus_pkg::status_t    st_main,
    input  game_bus_pkg::status_t    st_video,
    input  game_bus_pkg::status_t    st_snd,
    input  logic                     prio,
    input  game_bus_pkg::debug_sel_t debug_sel,
    output logic                     cfg,
    output game_bus_pkg::status_t    debug_view
);

    // Board variant from the download header
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg <= 1'b0;
        end else if (prog.we && prog.header && prog.addr == `GAME_HDR_ADDR) begin
            cfg <= prog.data[0];
        end
    end

    always_ff @(posedge clk) begin
        case (debug_sel)
            2'd0:    debug_view <= st_main;
            2'd1:    debug_view <= st_video;
            2'd2:    debug_view <= st_snd;
            default: debug_view <= {3'd0, prio, 3'd0, cfg};
        endcase
    end

endmodule

// File: video/layer_mix.sv
module layer_mix (
    input  logic                       clk,
    input  logic                       reset,
    input  game_video_pkg::layer_pxl_t tile_pxl,
    input  game_video_pkg::layer_pxl_t obj_pxl,
    input  logic                       pxl_cen,
    input  logic                       blank,
    input  logic                       prio,
    output game_video_pkg::mix_pxl_t   mix,
    output game_bus_pkg::status_t      st_video
);

    logic       tile_opaque;
    logic       obj_opaque;
    logic       use_obj;
    logic       valid_q;
    logic       blank_q;
    logic [7:0] idx_q;

    assign tile_opaque = |tile_pxl.col;
    assign obj_opaque  = |obj_pxl.col;

    // prio set puts the tile layer in front
    assign use_obj = obj_opaque && (!prio || !tile_opaque);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pxl_cen;
        end
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            blank_q <= blank;
            idx_q   <= use_obj ? {1'b1, obj_pxl.pal, obj_pxl.col}
                               : {1'b0, tile_pxl.pal, tile_pxl.col};
        end
    end

    assign mix = '{valid: valid_q, blank: blank_q, idx: idx_q};

    // Visible object wins
    always_ff @(posedge clk) begin
        if (reset) begin
            st_video <= '0;
        end else if (pxl_cen && !blank && use_obj) begin
            st_video <= st_video + 8'd1;
        end
    end

    assert property (@(posedge clk) disable iff (reset) mix.valid |-> $past(pxl_cen))
        else $error("mixed pixel valid without a pixel strobe");

endmodule

// File: video/pal_lookup.sv
`include "game_consts.svh"

module pal_lookup (
    input  logic                     clk,
    input  game_video_pkg::mix_pxl_t mix,
    input  logic                     pal_we,
    input  logic [8:0]               pal_addr,
    input  logic [7:0]               pal_data,
    output logic                     pxl_valid,
    output game_video_pkg::rgb_t     colour
);

    game_video_pkg::pal_word_u pal_ram [`GAME_PAL_WORDS];
    game_video_pkg::pal_word_u rd_word;
    logic                      blank_q;

    // CPU writes one byte lane, even address is the low byte
    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_ram[pal_addr[8:1]].raw[pal_addr[0]] <= pal_data;
        end
    end

    // Read sees the word as it was before a write in the same cycle
    always_ff @(posedge clk) begin
        if (mix.valid) begin
            rd_word <= pal_ram[mix.idx];
            blank_q <= mix.blank;
        end
    end

    // Valid follows the mixer by one cycle
    always_ff @(posedge clk) begin
        pxl_valid <= mix.valid;
    end

    always_comb begin
        if (blank_q) begin
            colour = '0;
        end else begin
            colour.red   = rd_word.rgb.red;
            colour.green = rd_word.rgb.green;
            colour.blue  = rd_word.rgb.blue;
        end
    end

endmodule

// File: source/game_top.sv
module game_top (
    input  logic                     clk,
    input  logic                     reset,
    input  game_bus_pkg::cpu_wr_t    cpu,
    input  game_bus_pkg::prog_wr_t   prog,
    input  logic                     snd_ack,
    input  game_video_pkg::layer_pxl_t tile_pxl,
    input  game_video_pkg::layer_pxl_t obj_pxl,
    input  logic                     pxl_cen,
    input  logic                     blank,
    input  game_bus_pkg::debug_sel_t debug_sel,
    output logic [7:0]               snd_latch,
    output logic                     snd_irq,
    output logic                     pxl_valid,
    output game_video_pkg::rgb_t     colour,
    output game_bus_pkg::status_t    debug_view
);

    // CPU side
    logic                   pal_we;
    logic [8:0]             pal_addr;
    logic [7:0]             pal_data;
    logic                   prio;
    logic                   latch_we;
    logic [7:0]             latch_data;
    logic                   cfg;
    game_bus_pkg::status_t  st_main;
    game_bus_pkg::status_t  st_video;
    game_bus_pkg::status_t  st_snd;

    // Pixel path
    game_video_pkg::mix_pxl_t mix;

    main_decode u_main (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .cpu        ( cpu        ),
        .cfg        ( cfg        ),
        .pal_we     ( pal_we     ),
        .pal_addr   ( pal_addr   ),
        .pal_data   ( pal_data   ),
        .prio       ( prio       ),
        .latch_we   ( latch_we   ),
        .latch_data ( latch_data ),
        .st_main    ( st_main    )
    );

    sound_latch u_latch (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .latch_we   ( latch_we   ),
        .latch_data ( latch_data ),
        .snd_ack    ( snd_ack    ),
        .snd_latch  ( snd_latch  ),
        .snd_irq    ( snd_irq    ),
        .st_snd     ( st_snd     )
    );

    game_status u_status (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .prog       ( prog       ),
        .st_main    ( st_main    ),
        .st_video   ( st_video   ),
        .st_snd     ( st_snd     ),
        .prio       ( prio       ),
        .debug_sel  ( debug_sel  ),
        .cfg        ( cfg        ),
        .debug_view ( debug_view )
    );

    layer_mix u_mix (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .tile_pxl   ( tile_pxl   ),
        .obj_pxl    ( obj_pxl    ),
        .pxl_cen    ( pxl_cen    ),
        .blank      ( blank      ),
        .prio       ( prio       ),
        .mix        ( mix        ),
        .st_video   ( st_video   )
    );

    pal_lookup u_pal (
        .clk        ( clk        ),
        .mix        ( mix        ),
        .pal_we     ( pal_we     ),
        .pal_addr   ( pal_addr   ),
        .pal_data   ( pal_data   ),
        .pxl_valid  ( pxl_valid  ),
        .colour     ( colour     )
    );

endmodule

// File: verification/game_tb.sv
`include "game_consts.svh"

module game_tb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [2:0] {
        op_cpu, op_hdr, op_pixel, op_ack, op_debug
    } kind_t;

    // One stimulus step with the response expected after it
    typedef struct packed {
        kind_t                      kind;
        logic [15:0]                addr;
        logic [7:0]                 data;
        game_video_pkg::layer_pxl_t tile;
        game_video_pkg::layer_pxl_t obj;
        logic                       blank;
        game_bus_pkg::debug_sel_t   sel;
        game_video_pkg::rgb_t       exp_rgb;
        game_bus_pkg::status_t      exp_status;
        logic [7:0]                 exp_latch;
        logic                       exp_irq;
        logic                       chk_latch;
    } entry_t;

    logic                       clk;
    logic                       reset;
    game_bus_pkg::cpu_wr_t      cpu;
    game_bus_pkg::prog_wr_t     prog;
    logic                       snd_ack;
    game_video_pkg::layer_pxl_t tile_pxl;
    game_video_pkg::layer_pxl_t obj_pxl;
    logic                       pxl_cen;
    logic                       blank;
    game_bus_pkg::debug_sel_t   debug_sel;
    logic [7:0]                 snd_latch;
    logic                       snd_irq;
    logic                       pxl_valid;
    game_video_pkg::rgb_t       colour;
    game_bus_pkg::status_t      debug_view;

    entry_t               table_q[$];
    game_video_pkg::rgb_t exp_q[$];
    int                   due_q[$];
    entry_t               e;
    int                   error_count;
    bit                   streaming;
    int                   neg_count;

    // Reference model state
    logic [7:0] m_bytes [2*`GAME_PAL_WORDS];
    logic       m_prio;
    logic       m_cfg;
    logic [7:0] m_latch;
    logic       m_irq;
    logic       m_latch_known;
    logic [7:0] m_st_main;
    logic [7:0] m_st_video;
    logic [7:0] m_st_snd;

    game_top dut (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .cpu        ( cpu        ),
        .prog       ( prog       ),
        .snd_ack    ( snd_ack    ),
        .tile_pxl   ( tile_pxl   ),
        .obj_pxl    ( obj_pxl    ),
        .pxl_cen    ( pxl_cen    ),
        .blank      ( blank      ),
        .debug_sel  ( debug_sel  ),
        .snd_latch  ( snd_latch  ),
        .snd_irq    ( snd_irq    ),
        .pxl_valid  ( pxl_valid  ),
        .colour     ( colour     ),
        .debug_view ( debug_view )
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic stop_on_error();
        error_count++;
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_rgb(input game_video_pkg::rgb_t exp);
        if (colour !== exp) begin
            $display("ERR colour got %h expected %h", colour, exp);
            stop_on_error();
        end
    endtask

    task automatic check_status(input game_bus_pkg::status_t exp);
        if (debug_view !== exp) begin
            $display("ERR debug_view got %h expected %h", debug_view, exp);
            stop_on_error();
        end
    endtask

    task automatic check_latch(input logic [7:0] exp_byte, input logic exp_irq);
        if (snd_latch !== exp_byte) begin
            $display("ERR snd_latch got %h expected %h", snd_latch, exp_byte);
            stop_on_error();
        end
        if (snd_irq !== exp_irq) begin
            $display("ERR snd_irq got %h expected %h", snd_irq, exp_irq);
            stop_on_error();
        end
    endtask

    // Mixing rule, idx is {obj, pal, col}
    function automatic logic [7:0] pick_index(input game_video_pkg::layer_pxl_t tile,
                                              input game_video_pkg::layer_pxl_t obj,
                                              input logic prio);
        logic obj_wins;
        if (!prio) begin
            obj_wins = obj.col != 4'd0;
        end else begin
            obj_wins = tile.col == 4'd0 && obj.col != 4'd0;
        end
        return obj_wins ? {1'b1, obj.pal, obj.col} : {1'b0, tile.pal, tile.col};
    endfunction

    // Colour from two palette bytes, red in the low bits of the even byte
    function automatic game_video_pkg::rgb_t expect_colour(input logic [7:0] idx,
                                                           input logic blk);
        logic [15:0]          word;
        game_video_pkg::rgb_t c;
        word    = {m_bytes[{idx, 1'b1}], m_bytes[{idx, 1'b0}]};
        c.red   = word[4:0];
        c.green = word[9:5];
        c.blue  = word[14:10];
        return blk ? '0 : c;
    endfunction

    function automatic game_video_pkg::layer_pxl_t random_pxl(input logic opaque);
        game_video_pkg::layer_pxl_t p;
        p.pal = 3'($urandom);
        p.col = opaque ? 4'($urandom % 15 + 1) : 4'd0;
        return p;
    endfunction

    task automatic add_cpu_write(input logic [15:0] addr, input logic [7:0] data);
        entry_t n;
        n = '0;
        if (addr >= `GAME_PAL_BASE && addr <= `GAME_PAL_LAST) begin
            m_bytes[addr[8:0]] = data;
            m_st_main++;
        end
        if (addr == `GAME_PRIO_ADDR) begin
            m_prio = data[0];
        end
        if (addr == (m_cfg ? `GAME_LATCH_ADDR1 : `GAME_LATCH_ADDR0)) begin
            m_latch       = data;
            m_irq         = 1'b1;
            m_latch_known = 1'b1;
            m_st_snd++;
        end
        n.kind      = op_cpu;
        n.addr      = addr;
        n.data      = data;
        n.exp_latch = m_latch;
        n.exp_irq   = m_irq;
        n.chk_latch = m_latch_known;
        table_q.push_back(n);
    endtask

    task automatic add_header(input logic [7:0] data);
        entry_t n;
        n      = '0;
        m_cfg  = data[0];
        n.kind = op_hdr;
        n.data = data;
        table_q.push_back(n);
    endtask

    task automatic add_pixel(input game_video_pkg::layer_pxl_t tile,
                             input game_video_pkg::layer_pxl_t obj, input logic blk);
        entry_t     n;
        logic [7:0] idx;
        n   = '0;
        idx = pick_index(tile, obj, m_prio);
        if (idx[7] && !blk) begin
            m_st_video++;
        end
        n.kind    = op_pixel;
        n.tile    = tile;
        n.obj     = obj;
        n.blank   = blk;
        n.exp_rgb = expect_colour(idx, blk);
        table_q.push_back(n);
    endtask

    // exp_irq is the level still pending before the acknowledge
    task automatic add_ack();
        entry_t n;
        n           = '0;
        n.kind      = op_ack;
        n.exp_latch = m_latch;
        n.exp_irq   = m_irq;
        n.chk_latch = m_latch_known;
        m_irq       = 1'b0;
        table_q.push_back(n);
    endtask

    task automatic add_debug(input game_bus_pkg::debug_sel_t sel);
        entry_t n;
        n      = '0;
        n.kind = op_debug;
        n.sel  = sel;
        case (sel)
            2'd0:    n.exp_status = m_st_main;
            2'd1:    n.exp_status = m_st_video;
            2'd2:    n.exp_status = m_st_snd;
            default: begin
                n.exp_status    = '0;
                n.exp_status[4] = m_prio;
                n.exp_status[0] = m_cfg;
            end
        endcase
        table_q.push_back(n);
    endtask

    task automatic add_pixel_set(input int count);
        for (int c = 0; c < 4; c++) begin
            add_pixel(random_pxl(c[0]), random_pxl(c[1]), 1'b0);
        end
        add_pixel(random_pxl(1'b1), random_pxl(1'b1), 1'b1);
        for (int i = 0; i < count; i++) begin
            add_pixel(random_pxl($urandom % 4 != 0), random_pxl($urandom % 2 != 0),
                      $urandom % 5 == 0);
        end
    endtask

    task automatic build_table();
        for (int i = 0; i < 2*`GAME_PAL_WORDS; i++) begin
            add_cpu_write(`GAME_PAL_BASE + 16'(i), 8'($urandom));
        end
        add_pixel_set(12);
        add_cpu_write(`GAME_PRIO_ADDR, 8'h01);
        add_pixel_set(12);
        add_cpu_write(`GAME_LATCH_ADDR0, 8'hA5);
        add_ack();
        add_cpu_write(`GAME_LATCH_ADDR0, 8'h3C);
        for (int s = 0; s < 4; s++) begin
            add_debug(2'(s));
        end
        add_ack();
        // Second board variant moves the latch
        add_header(8'h01);
        add_cpu_write(`GAME_LATCH_ADDR0, 8'h77);
        add_cpu_write(`GAME_LATCH_ADDR1, 8'h5A);
        add_debug(2'd3);
        add_ack();
        add_cpu_write(`GAME_PRIO_ADDR, 8'h00);
        add_debug(2'd3);
        for (int i = 0; i < 20; i++) begin
            add_cpu_write(`GAME_PAL_BASE + 16'($urandom % 512), 8'($urandom));
        end
        add_pixel_set(8);
        for (int s = 0; s < 3; s++) begin
            add_debug(2'(s));
        end
    endtask

    task automatic drain_pixels();
        int cycles;
        cycles = 0;
        @(posedge clk);
        pxl_cen   <= 1'b0;
        streaming = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > 1000) begin
                $display("Timeout waiting for pixels to leave the pipeline");
                stop_on_error();
            end
        end
    endtask

    // Pixels leave the pipeline in order, two cycles after their strobe
    always @(negedge clk) begin
        neg_count++;
        if (!reset && pxl_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Pixel output appeared with no pixel sent");
                stop_on_error();
            end else begin
                if (due_q.pop_front() != neg_count) begin
                    $display("Pixel output did not appear two cycles after its strobe");
                    stop_on_error();
                end
                check_rgb(exp_q.pop_front());
            end
        end
    end

    initial begin
        void'($urandom(32'h8741));
        reset       = 1'b1;
        cpu         = '0;
        prog        = '0;
        snd_ack     = 1'b0;
        tile_pxl    = '0;
        obj_pxl     = '0;
        pxl_cen     = 1'b0;
        blank       = 1'b0;
        debug_sel   = '0;
        streaming   = 1'b0;
        error_count = 0;
        m_prio = 1'b0;
        m_cfg  = 1'b0;
        m_latch = '0;
        m_irq  = 1'b0;
        m_latch_known = 1'b0;
        m_st_main  = '0;
        m_st_video = '0;
        m_st_snd   = '0;
        build_table();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < table_q.size(); i++) begin
            e = table_q[i];
            if (e.kind != op_pixel && streaming) begin
                drain_pixels();
            end
            case (e.kind)
                op_cpu: begin
                    @(posedge clk);
                    cpu <= '{we: 1'b1, addr: e.addr, data: e.data};
                    @(posedge clk);
                    cpu <= '0;
                    @(negedge clk);
                    if (e.chk_latch) begin
                        check_latch(e.exp_latch, e.exp_irq);
                    end
                end
                op_hdr: begin
                    @(posedge clk);
                    prog <= '{we: 1'b1, header: 1'b1, addr: `GAME_HDR_ADDR, data: e.data};
                    @(posedge clk);
                    prog <= '0;
                end
                op_pixel: begin
                    @(posedge clk);
                    tile_pxl  <= e.tile;
                    obj_pxl   <= e.obj;
                    blank     <= e.blank;
                    pxl_cen   <= 1'b1;
                    streaming = 1'b1;
                    exp_q.push_back(e.exp_rgb);
                    due_q.push_back(neg_count + 3);
                end
                op_ack: begin
                    @(negedge clk);
                    if (e.chk_latch) begin
                        check_latch(e.exp_latch, e.exp_irq);
                    end
                    @(posedge clk);
                    snd_ack <= 1'b1;
                    @(posedge clk);
                    snd_ack <= 1'b0;
                    @(negedge clk);
                    if (e.chk_latch) begin
                        check_latch(e.exp_latch, 1'b0);
                    end
                end
                default: begin
                    @(posedge clk);
                    debug_sel <= e.sel;
                    @(posedge clk);
                    @(negedge clk);
                    check_status(e.exp_status);
                end
            endcase
        end
        if (streaming) begin
            drain_pixels();
        end
        if (error_count == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

// File: verilog.f
+incdir+common
common/game_bus_pkg.sv
common/game_video_pkg.sv
source/main_decode.sv
source/sound_latch.sv
source/game_status.sv
video/layer_mix.sv
video/pal_lookup.sv
source/game_top.sv
verification/game_tb.sv

// File: Bender.yml
package:
  name: game_core

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/game_bus_pkg.sv
      - common/game_video_pkg.sv
      - source/main_decode.sv
      - source/sound_latch.sv
      - source/game_status.sv
      - video/layer_mix.sv
      - video/pal_lookup.sv
      - source/game_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verification/game_tb.sv
